//--- sim/fetch_golden.hex
// op(1) valid(1) operand(4) wdata(8) fip(2) packet(32), op 1 write 2 bad write
// 3 resteer 4 consume 5 stall, packet byte 15 leftmost
500002000000000000000000000000000000000000000000
300000000000000000000000000000000000000000000000
100000030201000000000000000000000000000000000000
100004070605040000000000000000000000000000000000
1000080b0a09080000000000000000000000000000000000
10000c0f0e0d0c0000000000000000000000000000000000
100010131211100000000000000000000000000000000000
100014171615140000000000000000000000000000000000
1000181b1a19180000000000000000000000000000000000
11001c1f1e1d1c000f0e0d0c0b0a09080706050403020100
210104deadbeef000f0e0d0c0b0a09080706050403020100
1100202322212000 0f0e0d0c0b0a09080706050403020100
1100242726252400 0f0e0d0c0b0a09080706050403020100
1100282b2a292800 0f0e0d0c0b0a09080706050403020100
11002c2f2e2d2c00 0f0e0d0c0b0a09080706050403020100
1100f0f3f2f1f000 0f0e0d0c0b0a09080706050403020100
1100f4f7f6f5f400 0f0e0d0c0b0a09080706050403020100
1100f8fbfaf9f800 0f0e0d0c0b0a09080706050403020100
1100fcfffefdfc00 0f0e0d0c0b0a09080706050403020100
31001a000000001a292827262524232221201f1e1d1c1b1a
3100f800000000f80706050403020100fffefdfcfbfaf9f8
31000000000000000f0e0d0c0b0a09080706050403020100
51000300000000000f0e0d0c0b0a09080706050403020100
410005000000000514131211100f0e0d0c0b0a0908070605
41000f0000000014232221201f1e1d1c1b1a191817161514
40000c000000002000000000000000000000000000000000
500002000000002000000000000000000000000000000000

//--- files.f
+incdir+source
source/fetch_pkg.sv
source/fetch_apb_fill.sv
source/fetch_bank.sv
source/fetch_aligner.sv
source/fetch_top.sv
sim/tb_fetch.sv

//--- Makefile
# Verilator build and run for the fetch front end

VERILATOR ?= verilator
TOP       ?= tb_fetch
FLAGS     ?= --binary -Wno-fatal
OBJ_DIR   ?= obj_dir
FILELIST  ?= files.f

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FLAGS OBJ_DIR FILELIST"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out=$$(./$(OBJ_DIR)/V$(TOP) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf $(OBJ_DIR)

//--- sim/tb_fetch.sv
`include "fetch_settings.svh"

module tb_fetch
    import fetch_pkg::*;
();

    localparam int NUM_REC     = 27;
    localparam int REC_W       = 192;
    localparam int FILL_WORDS  = 64;
    localparam int SWEEP_LEN   = 40;
    localparam int CYCLE_LIMIT = NUM_REC * 8 + FILL_WORDS * 4 + SWEEP_LEN * 4 + 200;

    localparam logic [3:0] OP_WRITE     = 4'h1;
    localparam logic [3:0] OP_BAD_WRITE = 4'h2;
    localparam logic [3:0] OP_RESTEER   = 4'h3;
    localparam logic [3:0] OP_CONSUME   = 4'h4;
    localparam logic [3:0] OP_STALL     = 4'h5;

    logic                                 clk;
    logic                                 rst_n;
    logic                                 psel;
    logic                                 penable;
    logic                                 pwrite;
    logic [`FETCH_APB_AW-1:0]             paddr;
    logic [31:0]                          pwdata;
    logic                                 pready;
    logic [31:0]                          prdata;
    logic                                 pslverr;
    logic                                 resteer;
    fip_t                                 target;
    logic                                 stall;
    logic [$clog2(`FETCH_LINE_BYTES)-1:0] length;
    fetch_line_u                          packet;
    fip_t                                 packet_fip;
    logic                                 packet_valid;

    logic [REC_W-1:0] golden [NUM_REC];
    logic [7:0]       model_mem [256];
    logic             model_fill [FILL_WORDS];
    integer           seed;
    int               cycle_count = 0;

    fetch_top fetch_top_inst (
        .clk_i          (clk),
        .rst_n_i        (rst_n),
        .psel_i         (psel),
        .penable_i      (penable),
        .pwrite_i       (pwrite),
        .paddr_i        (paddr),
        .pwdata_i       (pwdata),
        .pready_o       (pready),
        .prdata_o       (prdata),
        .pslverr_o      (pslverr),
        .resteer_i      (resteer),
        .target_i       (target),
        .stall_i        (stall),
        .length_i       (length),
        .packet_o       (packet),
        .packet_fip_o   (packet_fip),
        .packet_valid_o (packet_valid)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            abort_run($sformatf("timeout, run still busy after %0d cycles", cycle_count));
        end
    end

    //////////////////////////////////////////////////////////////////////
    // reporting and compares
    //////////////////////////////////////////////////////////////////////

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("sim failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_packet(input fetch_line_u got, input fetch_line_u exp);
        if (got !== exp) begin
            abort_run($sformatf("FAIL packet_o got %h expected %h", got, exp));
        end
    endtask

    task automatic check_fip(input fip_t got, input fip_t exp);
        if (got !== exp) begin
            abort_run($sformatf("FAIL packet_fip_o got %h expected %h", got, exp));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("FAIL %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("FAIL %s got %h expected %h", name, got, exp));
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // golden file
    //////////////////////////////////////////////////////////////////////

    function automatic int hex_value(input byte c);
        if (c >= "0" && c <= "9") begin
            return c - "0";
        end
        if (c >= "a" && c <= "f") begin
            return c - "a" + 10;
        end
        if (c >= "A" && c <= "F") begin
            return c - "A" + 10;
        end
        return -1;
    endfunction

    // one record per line, spaces inside a record are skipped
    task automatic load_golden();
        int               fd;
        int               n;
        int               digits;
        int               v;
        byte              c;
        string            line;
        logic [REC_W-1:0] rec;
        fd = $fopen("sim/fetch_golden.hex", "r");
        if (fd == 0) begin
            abort_run("cannot open the golden file sim/fetch_golden.hex");
        end
        n = 0;
        while ($fgets(line, fd) > 0) begin
            rec    = '0;
            digits = 0;
            for (int i = 0; i < line.len(); i++) begin
                c = line.getc(i);
                // rest of the line is a comment
                if (c == "/") begin
                    break;
                end
                v = hex_value(c);
                if (v >= 0) begin
                    rec = {rec[REC_W-5:0], 4'(v)};
                    digits++;
                end
            end
            if (digits == 0) begin
                continue;
            end
            if (digits != REC_W / 4) begin
                abort_run($sformatf("golden record %0d has %0d hex digits", n, digits));
            end
            if (n >= NUM_REC) begin
                abort_run("golden file holds more records than expected");
            end
            golden[n] = rec;
            n++;
        end
        $fclose(fd);
        if (n != NUM_REC) begin
            abort_run($sformatf("golden file holds %0d records instead of %0d", n, NUM_REC));
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // reference model of program memory
    //////////////////////////////////////////////////////////////////////

    // every address bit reaches the value
    function automatic logic [7:0] fill_byte(input logic [7:0] addr);
        return (addr * 8'd37) ^ 8'h5b;
    endfunction

    function automatic fetch_line_u model_packet(input fip_t fip);
        fetch_line_u p;
        for (int i = 0; i < `FETCH_LINE_BYTES; i++) begin
            p.bytes[i] = model_mem[fip + fip_t'(i)];
        end
        return p;
    endfunction

    // line holding fip and the line after it, wrapping
    function automatic logic model_valid(input fip_t fip);
        logic [3:0] lo;
        logic [3:0] hi;
        logic       ok;
        lo = fip[7:4];
        hi = lo + 4'd1;
        ok = 1'b1;
        for (int w = 0; w < 4; w++) begin
            ok = ok & model_fill[{lo, 2'(w)}] & model_fill[{hi, 2'(w)}];
        end
        return ok;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // bus and fetch drivers
    //////////////////////////////////////////////////////////////////////

    task automatic apb_write(input logic [`FETCH_APB_AW-1:0] addr, input logic [31:0] data,
                             input logic bad);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b1;
        paddr   <= addr;
        pwdata  <= data;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        check_bit("pready_o", pready, 1'b1);
        check_bit("pslverr_o", pslverr, bad);
        // the line changes at this edge
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
        if (!bad) begin
            for (int b = 0; b < 4; b++) begin
                model_mem[addr[7:0] + 8'(b)] = data[8*b +: 8];
            end
            model_fill[addr[7:2]] = 1'b1;
        end
    endtask

    // reads return zero whatever the memory holds
    task automatic apb_read(input logic [`FETCH_APB_AW-1:0] addr);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        paddr   <= addr;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        check_bit("pready_o", pready, 1'b1);
        check_bit("pslverr_o", pslverr, 1'b0);
        check_word("prdata_o", prdata, 32'h0);
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic do_resteer(input fip_t fip);
        @(posedge clk);
        resteer <= 1'b1;
        target  <= fip;
        @(posedge clk);
        resteer <= 1'b0;
    endtask

    task automatic do_consume(input logic [3:0] len);
        @(posedge clk);
        stall  <= 1'b0;
        length <= len;
        @(posedge clk);
        stall  <= 1'b1;
    endtask

    task automatic check_outputs(input fip_t fip, input logic valid, input fetch_line_u pkt);
        @(negedge clk);
        check_fip(packet_fip, fip);
        check_bit("packet_valid_o", packet_valid, valid);
        // bytes of an invalid packet carry no meaning
        if (valid) begin
            check_packet(packet, pkt);
        end
    endtask

    task automatic run_record(input logic [REC_W-1:0] rec);
        logic [3:0]  op;
        logic [15:0] opa;
        fetch_line_u pkt;
        op  = rec[191:188];
        opa = rec[183:168];
        pkt = rec[127:0];
        case (op)
            OP_WRITE, OP_BAD_WRITE: begin
                apb_write(opa[`FETCH_APB_AW-1:0], rec[167:136], op == OP_BAD_WRITE);
                // packet register picks up the new line one edge later
                @(posedge clk);
            end
            OP_RESTEER: do_resteer(opa[7:0]);
            OP_CONSUME: do_consume(opa[3:0]);
            OP_STALL:   repeat (opa) @(posedge clk);
            default:    abort_run($sformatf("golden record has unknown opcode %h", op));
        endcase
        check_outputs(rec[135:128], rec[184], pkt);
    endtask

    //////////////////////////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        fip_t       exp_fip;
        logic [3:0] len;
        logic [7:0] base;
        seed    = 45;
        rst_n   = 1'b0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        resteer = 1'b0;
        target  = '0;
        stall   = 1'b1;
        length  = '0;
        for (int w = 0; w < FILL_WORDS; w++) begin
            model_fill[w] = 1'b0;
        end
        load_golden();
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;

        for (int r = 0; r < NUM_REC; r++) begin
            run_record(golden[r]);
        end

        // whole memory for the random sweep
        for (int w = 0; w < FILL_WORDS; w++) begin
            base = 8'(w * 4);
            apb_write(`FETCH_APB_AW'(base), {fill_byte(base + 8'd3), fill_byte(base + 8'd2),
                                             fill_byte(base + 8'd1), fill_byte(base)}, 1'b0);
        end

        // word 0 now holds nonzero bytes
        apb_read(`FETCH_APB_AW'(8'h00));

        exp_fip = 8'h37;
        do_resteer(exp_fip);
        check_outputs(exp_fip, model_valid(exp_fip), model_packet(exp_fip));
        for (int n = 0; n < SWEEP_LEN; n++) begin
            len = 4'(1 + ($unsigned($random(seed)) % 15));
            do_consume(len);
            exp_fip = exp_fip + fip_t'(len);
            check_outputs(exp_fip, model_valid(exp_fip), model_packet(exp_fip));
        end

        $display("sim passed");
        $finish;
    end

endmodule

//--- source/fetch_top.sv
`include "fetch_settings.svh"

module fetch_top
    import fetch_pkg::*;
(
    input  logic                                 clk_i,
    input  logic                                 rst_n_i,

    //////////////////////////////////////////////////////////////////////
    // apb fill port
    //////////////////////////////////////////////////////////////////////
    input  logic                                 psel_i,
    input  logic                                 penable_i,
    input  logic                                 pwrite_i,
    input  logic [`FETCH_APB_AW-1:0]             paddr_i,
    input  logic [31:0]                          pwdata_i,
    output logic                                 pready_o,
    output logic [31:0]                          prdata_o,
    output logic                                 pslverr_o,

    //////////////////////////////////////////////////////////////////////
    // decode port
    //////////////////////////////////////////////////////////////////////
    input  logic                                 resteer_i,
    input  fip_t                                 target_i,
    input  logic                                 stall_i,
    input  logic [$clog2(`FETCH_LINE_BYTES)-1:0] length_i,
    output fetch_line_u                          packet_o,
    output fip_t                                 packet_fip_o,
    output logic                                 packet_valid_o
);

    logic        wr_even;
    logic        wr_odd;
    line_idx_t   wr_line;
    word_idx_t   wr_word;
    logic [31:0] wr_data;

    line_idx_t   even_line;
    line_idx_t   odd_line;
    fetch_line_u even_data;
    fetch_line_u odd_data;
    logic        even_valid;
    logic        odd_valid;

    fetch_apb_fill u_apb_fill (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .psel_i    (psel_i),
        .penable_i (penable_i),
        .pwrite_i  (pwrite_i),
        .paddr_i   (paddr_i),
        .pwdata_i  (pwdata_i),
        .pready_o  (pready_o),
        .prdata_o  (prdata_o),
        .pslverr_o (pslverr_o),
        .wr_even_o (wr_even),
        .wr_odd_o  (wr_odd),
        .wr_line_o (wr_line),
        .wr_word_o (wr_word),
        .wr_data_o (wr_data)
    );

    // lines with address bit 4 clear
    fetch_bank u_bank_even (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .wr_en_i    (wr_even),
        .wr_line_i  (wr_line),
        .wr_word_i  (wr_word),
        .wr_data_i  (wr_data),
        .rd_line_i  (even_line),
        .rd_data_o  (even_data),
        .rd_valid_o (even_valid)
    );

    // lines with address bit 4 set
    fetch_bank u_bank_odd (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .wr_en_i    (wr_odd),
        .wr_line_i  (wr_line),
        .wr_word_i  (wr_word),
        .wr_data_i  (wr_data),
        .rd_line_i  (odd_line),
        .rd_data_o  (odd_data),
        .rd_valid_o (odd_valid)
    );

    fetch_aligner u_aligner (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .resteer_i      (resteer_i),
        .target_i       (target_i),
        .stall_i        (stall_i),
        .length_i       (length_i),
        .even_data_i    (even_data),
        .even_valid_i   (even_valid),
        .odd_data_i     (odd_data),
        .odd_valid_i    (odd_valid),
        .even_line_o    (even_line),
        .odd_line_o     (odd_line),
        .packet_o       (packet_o),
        .packet_fip_o   (packet_fip_o),
        .packet_valid_o (packet_valid_o)
    );

endmodule

//--- source/fetch_aligner.sv
`include "fetch_settings.svh"

module fetch_aligner
    import fetch_pkg::*;
(
    input  logic                                 clk_i,
    input  logic                                 rst_n_i,

    // from decode
    input  logic                                 resteer_i,
    input  fip_t                                 target_i,
    input  logic                                 stall_i,
    input  logic [$clog2(`FETCH_LINE_BYTES)-1:0] length_i,

    // lines from the two banks
    input  fetch_line_u                          even_data_i,
    input  logic                                 even_valid_i,
    input  fetch_line_u                          odd_data_i,
    input  logic                                 odd_valid_i,

    // bank read indices
    output line_idx_t                            even_line_o,
    output line_idx_t                            odd_line_o,

    // to decode
    output fetch_line_u                          packet_o,
    output fip_t                                 packet_fip_o,
    output logic                                 packet_valid_o
);

    localparam int OFF_W    = $clog2(`FETCH_LINE_BYTES);
    localparam int LINE_LSB = OFF_W + 1;

    fip_t                                  fip_q;
    fip_t                                  fip_d;
    logic                                  started_q;
    logic                                  started_d;
    logic                                  consume;

    line_idx_t                             line_k;
    logic                                  odd_first;
    logic [OFF_W-1:0]                      offset;

    fetch_line_u                           low_line;
    fetch_line_u                           high_line;
    logic [2*`FETCH_LINE_BYTES-1:0][7:0]   merged;

    fetch_line_u                           packet_d;
    logic                                  valid_d;
    fetch_line_u                           packet_q;
    logic                                  valid_q;

    //////////////////////////////////////////////////////////////////////
    // next fetch pointer
    //////////////////////////////////////////////////////////////////////

    // decode takes the packet only when nothing else is going on
    assign consume = valid_q & ~stall_i & ~resteer_i;

    always_comb begin
        fip_d = fip_q;
        if (resteer_i) begin
            fip_d = target_i;
        end else if (consume) begin
            // wraps at the top of the 256-byte space
            fip_d = fip_q + fip_t'(length_i);
        end
    end

    // nothing is fetched until software points us somewhere
    assign started_d = started_q | resteer_i;

    //////////////////////////////////////////////////////////////////////
    // bank indexing
    //////////////////////////////////////////////////////////////////////

    assign line_k    = fip_d[LINE_LSB +: $bits(line_idx_t)];
    assign odd_first = fip_d[OFF_W];
    assign offset    = fip_d[OFF_W-1:0];

    // pointer in an odd line needs the following even line
    // which is one index up and wraps past line 7
    assign even_line_o = odd_first ? line_idx_t'(line_k + 1'b1) : line_k;
    assign odd_line_o  = line_k;

    //////////////////////////////////////////////////////////////////////
    // merge and pick
    //////////////////////////////////////////////////////////////////////

    assign low_line  = odd_first ? odd_data_i  : even_data_i;
    assign high_line = odd_first ? even_data_i : odd_data_i;

    // 32 contiguous bytes starting at the low line base
    assign merged = {high_line.bytes, low_line.bytes};

    always_comb begin
        packet_d = '0;
        for (int i = 0; i < `FETCH_LINE_BYTES; i++) begin
            packet_d.bytes[i] = merged[int'(offset) + i];
        end
    end

    // both lines must be complete, even when the offset is zero
    assign valid_d = started_d & even_valid_i & odd_valid_i;

    //////////////////////////////////////////////////////////////////////
    // registers
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            fip_q     <= '0;
            started_q <= 1'b0;
            valid_q   <= 1'b0;
        end else begin
            fip_q     <= fip_d;
            started_q <= started_d;
            valid_q   <= valid_d;
        end
    end

    // reloaded every edge so a fill under stall shows up in the packet
    always_ff @(posedge clk_i) begin
        packet_q <= packet_d;
    end

    assign packet_o       = packet_q;
    assign packet_fip_o   = fip_q;
    assign packet_valid_o = valid_q;

endmodule

//--- source/fetch_bank.sv
`include "fetch_settings.svh"

module fetch_bank
    import fetch_pkg::*;
(
    input  logic        clk_i,
    input  logic        rst_n_i,

    // fill side
    input  logic        wr_en_i,
    input  line_idx_t   wr_line_i,
    input  word_idx_t   wr_word_i,
    input  logic [31:0] wr_data_i,

    // fetch side
    input  line_idx_t   rd_line_i,
    output fetch_line_u rd_data_o,
    output logic        rd_valid_o
);

    localparam int WORDS = `FETCH_LINE_BYTES / 4;

    fetch_line_u            mem [`FETCH_BANK_LINES];

    // one bit per written word of every line
    logic [WORDS-1:0]       fill_q [`FETCH_BANK_LINES];

    //////////////////////////////////////////////////////////////////////
    // line storage
    //////////////////////////////////////////////////////////////////////

    // word write through the dword view
    always_ff @(posedge clk_i) begin
        if (wr_en_i) begin
            mem[wr_line_i].dwords[wr_word_i] <= wr_data_i;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // fill tracking
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int l = 0; l < `FETCH_BANK_LINES; l++) begin
                fill_q[l] <= '0;
            end
        end else if (wr_en_i) begin
            fill_q[wr_line_i][wr_word_i] <= 1'b1;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // read port
    //////////////////////////////////////////////////////////////////////

    // combinational so the aligner sees the line in the same cycle
    assign rd_data_o  = mem[rd_line_i];

    // usable only once every word has landed
    assign rd_valid_o = &fill_q[rd_line_i];

endmodule

//--- source/fetch_apb_fill.sv
`include "fetch_settings.svh"

module fetch_apb_fill
    import fetch_pkg::*;
(
    input  logic                     clk_i,
    input  logic                     rst_n_i,

    // apb slave
    input  logic                     psel_i,
    input  logic                     penable_i,
    input  logic                     pwrite_i,
    input  logic [`FETCH_APB_AW-1:0] paddr_i,
    input  logic [31:0]              pwdata_i,
    output logic                     pready_o,
    output logic [31:0]              prdata_o,
    output logic                     pslverr_o,

    // write strobes to the two banks
    output logic                     wr_even_o,
    output logic                     wr_odd_o,
    output line_idx_t                wr_line_o,
    output word_idx_t                wr_word_o,
    output logic [31:0]              wr_data_o
);

    localparam int WORD_LSB = 2;
    localparam int BANK_BIT = $clog2(`FETCH_LINE_BYTES);
    localparam int LINE_LSB = BANK_BIT + 1;

    logic setup_q;
    logic access;
    logic addr_err;
    logic wr_ok;

    //////////////////////////////////////////////////////////////////////
    // phase tracking
    //////////////////////////////////////////////////////////////////////

    // remember a setup phase so a bare access phase is not taken as a write
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            setup_q <= 1'b0;
        end else begin
            setup_q <= psel_i & ~penable_i;
        end
    end

    assign access = psel_i & penable_i;

    // nothing lives above the 256-byte program space
    assign addr_err = |paddr_i[`FETCH_APB_AW-1:`FETCH_FIP_W];

    assign wr_ok = access & setup_q & pwrite_i & ~addr_err;

    //////////////////////////////////////////////////////////////////////
    // response
    //////////////////////////////////////////////////////////////////////

    // no wait states
    assign pready_o  = access;
    assign pslverr_o = access & addr_err;

    // memory is write only from this side
    assign prdata_o  = '0;

    //////////////////////////////////////////////////////////////////////
    // address decode
    //////////////////////////////////////////////////////////////////////

    // bit 4 picks the bank
    assign wr_even_o = wr_ok & ~paddr_i[BANK_BIT];
    assign wr_odd_o  = wr_ok &  paddr_i[BANK_BIT];

    assign wr_line_o = paddr_i[LINE_LSB +: $bits(line_idx_t)];
    assign wr_word_o = paddr_i[WORD_LSB +: $bits(word_idx_t)];
    assign wr_data_o = pwdata_i;

endmodule

//--- source/fetch_pkg.sv
`include "fetch_settings.svh"

package fetch_pkg;

    //////////////////////////////////////////////////////////////////////
    // pointer and index types
    //////////////////////////////////////////////////////////////////////

    // byte address into program memory
    typedef logic [`FETCH_FIP_W-1:0] fip_t;

    // line within one bank
    typedef logic [$clog2(`FETCH_BANK_LINES)-1:0] line_idx_t;

    // 32-bit word within one line
    typedef logic [$clog2(`FETCH_LINE_BYTES/4)-1:0] word_idx_t;

    //////////////////////////////////////////////////////////////////////
    // line storage
    //////////////////////////////////////////////////////////////////////

    // one line seen two ways
    // bytes for the aligner, dwords for the fill path
    // byte 0 and the low byte of dword 0 share bits 7:0
    typedef union packed {
        logic [`FETCH_LINE_BYTES-1:0][7:0]    bytes;
        logic [`FETCH_LINE_BYTES/4-1:0][31:0] dwords;
    } fetch_line_u;

endpackage

//--- source/fetch_settings.svh
`ifndef FETCH_SETTINGS_SVH
`define FETCH_SETTINGS_SVH

//////////////////////////////////////////////////////////////////////
// program memory geometry
//////////////////////////////////////////////////////////////////////

// bytes per cache line
`define FETCH_LINE_BYTES 16

// lines held by each bank (even and odd)
`define FETCH_BANK_LINES 8

// fetch pointer covers the whole 256-byte space
`define FETCH_FIP_W 8

//////////////////////////////////////////////////////////////////////
// fill port
//////////////////////////////////////////////////////////////////////

`define FETCH_APB_AW 12

`endif
